// File: project.f
+incdir+include
src/fpMulPkg.sv
src/fpMulDecode.sv
src/fpMulSignificand.sv
src/fpMulNormRound.sv
src/fpMulTop.sv
tests/fpMulChecker.sv
tests/fpMulTb.sv

// File: src/fpMulDecode.sv
module fpMulDecode (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          inValid,
    input  logic [31:0]                   opX,
    input  logic [31:0]                   opY,
    input  logic [2:0]                    roundMode,
    output logic                          validD,
    output logic                          signD,
    output logic [fpMulPkg::expWidth-1:0] expXD,
    output logic [fpMulPkg::expWidth-1:0] expYD,
    output logic [fpMulPkg::fracWidth:0]  sigXD,
    output logic [fpMulPkg::fracWidth:0]  sigYD,
    output fpMulPkg::specialKind          kindD,
    output logic [2:0]                    modeD
);

    logic [fpMulPkg::expWidth-1:0]  expX;
    logic [fpMulPkg::expWidth-1:0]  expY;
    logic [fpMulPkg::fracWidth-1:0] fracX;
    logic [fpMulPkg::fracWidth-1:0] fracY;
    logic                           xZero;
    logic                           yZero;
    logic                           xInf;
    logic                           yInf;
    logic                           xNan;
    logic                           yNan;
    fpMulPkg::specialKind           kind;

    assign expX  = opX[fpMulPkg::fracWidth +: fpMulPkg::expWidth];
    assign expY  = opY[fpMulPkg::fracWidth +: fpMulPkg::expWidth];
    assign fracX = opX[fpMulPkg::fracWidth-1:0];
    assign fracY = opY[fpMulPkg::fracWidth-1:0];

    // subnormals count as zero, they get flushed
    assign xZero = (expX == '0);
    assign yZero = (expY == '0);
    assign xInf  = (expX == '1) && (fracX == '0);
    assign yInf  = (expY == '1) && (fracY == '0);
    assign xNan  = (expX == '1) && (fracX != '0);
    assign yNan  = (expY == '1) && (fracY != '0);

    always_comb begin
        if (xNan || yNan || (xInf && yZero) || (yInf && xZero)) begin
            kind = fpMulPkg::kindNan;
        end else if (xInf || yInf) begin
            kind = fpMulPkg::kindInf;
        end else if (xZero || yZero) begin
            kind = fpMulPkg::kindZero;
        end else begin
            kind = fpMulPkg::kindNone;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            validD <= 1'b0;
        end else begin
            validD <= inValid;
        end
    end

    // operand fields only move with a strobe
    always_ff @(posedge clk) begin
        if (inValid) begin
            signD <= opX[31] ^ opY[31];
            expXD <= expX;
            expYD <= expY;
            // hidden one
            sigXD <= {1'b1, fracX};
            sigYD <= {1'b1, fracY};
            kindD <= kind;
            modeD <= roundMode;
        end
    end

endmodule

// File: src/fpMulNormRound.sv
module fpMulNormRound (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 validE,
    input  logic                                 signE,
    input  logic signed [fpMulPkg::expWidth+1:0] expE,
    input  logic [fpMulPkg::sigProdWidth-1:0]    prodE,
    input  fpMulPkg::specialKind                 kindE,
    input  logic [2:0]                           modeE,
    output logic                                 outValid,
    output logic [31:0]                          result,
    output logic                                 overflow,
    output logic                                 underflow
);

    logic [fpMulPkg::normWidth-1:0]        normSig;
    logic signed [fpMulPkg::expWidth+1:0]  expNorm;
    logic                                  lsbBit;
    logic                                  guardBit;
    logic                                  stickyBit;
    logic                                  roundUp;
    logic [fpMulPkg::fracWidth+1:0]        roundSum;
    logic                                  roundCarry;
    logic [fpMulPkg::fracWidth:0]          roundSig;
    logic signed [fpMulPkg::expWidth+1:0]  expFinal;
    logic                                  isOverflow;
    logic                                  isUnderflow;
    logic                                  satToMax;
    logic [31:0]                           satWord;
    logic [31:0]                           resultNext;
    logic                                  overflowNext;
    logic                                  underflowNext;

    // normalize to 1.x, low bits fold into sticky
    always_comb begin
        if (prodE[fpMulPkg::sigProdWidth-1]) begin
            normSig = {prodE[fpMulPkg::sigProdWidth-1 -: fpMulPkg::normWidth-1],
                       |prodE[fpMulPkg::sigProdWidth-fpMulPkg::normWidth:0]};
        end else begin
            normSig = {prodE[fpMulPkg::sigProdWidth-2 -: fpMulPkg::normWidth-1],
                       |prodE[fpMulPkg::sigProdWidth-fpMulPkg::normWidth-1:0]};
        end
    end

    assign expNorm = expE + $signed({{(fpMulPkg::expWidth+1){1'b0}},
                                     prodE[fpMulPkg::sigProdWidth-1]});

    assign lsbBit    = normSig[3];
    assign guardBit  = normSig[2];
    assign stickyBit = normSig[1] | normSig[0];

    always_comb begin
        case (modeE)
            fpMulPkg::rmTowardZero: roundUp = 1'b0;
            // only inexact values move away from zero
            fpMulPkg::rmDown:       roundUp = signE & (guardBit | stickyBit);
            fpMulPkg::rmUp:         roundUp = ~signE & (guardBit | stickyBit);
            fpMulPkg::rmNearMax:    roundUp = guardBit;
            // nearest even, also used for unlisted codes
            default:                roundUp = guardBit & (stickyBit | lsbBit);
        endcase
    end

    assign roundSum   = {1'b0, normSig[fpMulPkg::normWidth-1:3]}
                      + {{(fpMulPkg::fracWidth+1){1'b0}}, roundUp};
    assign roundCarry = roundSum[fpMulPkg::fracWidth+1];

    // all ones rounded up becomes 1.0 with one more in the exponent
    assign roundSig = roundCarry ? roundSum[fpMulPkg::fracWidth+1:1]
                                 : roundSum[fpMulPkg::fracWidth:0];
    assign expFinal = expNorm + $signed({{(fpMulPkg::expWidth+1){1'b0}}, roundCarry});

    assign isOverflow  = (expFinal >= 255);
    assign isUnderflow = (expFinal <= 0);

    // saturate to max finite when the mode rounds toward zero for this sign
    always_comb begin
        case (modeE)
            fpMulPkg::rmTowardZero: satToMax = 1'b1;
            fpMulPkg::rmDown:       satToMax = ~signE;
            fpMulPkg::rmUp:         satToMax = signE;
            default:                satToMax = 1'b0;
        endcase
    end

    assign satWord = (satToMax ? fpMulPkg::maxFinite : fpMulPkg::posInf) | {signE, 31'b0};

    always_comb begin
        overflowNext  = 1'b0;
        underflowNext = 1'b0;
        case (kindE)
            fpMulPkg::kindNan:  resultNext = fpMulPkg::canonNan;
            fpMulPkg::kindInf:  resultNext = fpMulPkg::posInf | {signE, 31'b0};
            fpMulPkg::kindZero: resultNext = {signE, 31'b0};
            default: begin
                if (isOverflow) begin
                    resultNext   = satWord;
                    overflowNext = 1'b1;
                end else if (isUnderflow) begin
                    resultNext    = {signE, 31'b0};
                    underflowNext = 1'b1;
                end else begin
                    resultNext = {signE, expFinal[fpMulPkg::expWidth-1:0],
                                  roundSig[fpMulPkg::fracWidth-1:0]};
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= validE;
        end
    end

    always_ff @(posedge clk) begin
        if (validE) begin
            result    <= resultNext;
            overflow  <= overflowNext;
            underflow <= underflowNext;
        end
    end

endmodule

// File: src/fpMulPkg.sv
package fpMulPkg;

    // single-precision field widths
    localparam int expWidth = 8;
    localparam int fracWidth = 23;
    localparam int expBias = 127;

    // full 24 x 24 significand product
    localparam int sigProdWidth = 48;

    // 24 significand bits, then guard, round and sticky
    localparam int normWidth = 27;

    // rounding-mode codes
    localparam logic [2:0] rmNearEven = 3'b000;
    localparam logic [2:0] rmTowardZero = 3'b001;
    localparam logic [2:0] rmDown = 3'b010;
    localparam logic [2:0] rmUp = 3'b011;
    localparam logic [2:0] rmNearMax = 3'b100;

    // special encodings
    localparam logic [31:0] canonNan = 32'h7FC0_0000;
    localparam logic [31:0] posInf = 32'h7F80_0000;
    localparam logic [31:0] maxFinite = 32'h7F7F_FFFF;

    // special result decided at decode, applied at the last stage
    typedef enum logic [1:0] {
        kindNone,
        kindZero,
        kindInf,
        kindNan
    } specialKind;

    // cycles from inValid to outValid
    localparam int latency = 3;

endpackage

// File: src/fpMulSignificand.sv
module fpMulSignificand (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   validD,
    input  logic                                   signD,
    input  logic [fpMulPkg::expWidth-1:0]          expXD,
    input  logic [fpMulPkg::expWidth-1:0]          expYD,
    input  logic [fpMulPkg::fracWidth:0]           sigXD,
    input  logic [fpMulPkg::fracWidth:0]           sigYD,
    input  fpMulPkg::specialKind                   kindD,
    input  logic [2:0]                             modeD,
    output logic                                   validE,
    output logic                                   signE,
    output logic signed [fpMulPkg::expWidth+1:0]   expE,
    output logic [fpMulPkg::sigProdWidth-1:0]      prodE,
    output fpMulPkg::specialKind                   kindE,
    output logic [2:0]                             modeE
);

    logic signed [fpMulPkg::expWidth+1:0] expSum;
    logic [fpMulPkg::sigProdWidth-1:0]    product;

    // two guard bits keep overflow and negative sums visible
    assign expSum = $signed({2'b00, expXD})
                  + $signed({2'b00, expYD})
                  - $signed((fpMulPkg::expWidth+2)'(fpMulPkg::expBias));

    // unsigned 24 x 24, top bit set means product in [2, 4)
    assign product = sigXD * sigYD;

    always_ff @(posedge clk) begin
        if (reset) begin
            validE <= 1'b0;
        end else begin
            validE <= validD;
        end
    end

    always_ff @(posedge clk) begin
        if (validD) begin
            signE <= signD;
            expE  <= expSum;
            prodE <= product;
            kindE <= kindD;
            modeE <= modeD;
        end
    end

endmodule

// File: src/fpMulTop.sv
module fpMulTop (
    input  logic        clk,
    input  logic        reset,
    input  logic        inValid,
    input  logic [31:0] opX,
    input  logic [31:0] opY,
    input  logic [2:0]  roundMode,
    output logic        outValid,
    output logic [31:0] result,
    output logic        overflow,
    output logic        underflow
);

    // decode to execute
    logic                                 validD;
    logic                                 signD;
    logic [fpMulPkg::expWidth-1:0]        expXD;
    logic [fpMulPkg::expWidth-1:0]        expYD;
    logic [fpMulPkg::fracWidth:0]         sigXD;
    logic [fpMulPkg::fracWidth:0]         sigYD;
    fpMulPkg::specialKind                 kindD;
    logic [2:0]                           modeD;

    // execute to result
    logic                                 validE;
    logic                                 signE;
    logic signed [fpMulPkg::expWidth+1:0] expE;
    logic [fpMulPkg::sigProdWidth-1:0]    prodE;
    fpMulPkg::specialKind                 kindE;
    logic [2:0]                           modeE;

    fpMulDecode decodeStage (
        .clk(clk), .reset(reset), .inValid(inValid),
        .opX(opX), .opY(opY), .roundMode(roundMode),
        .validD(validD), .signD(signD), .expXD(expXD), .expYD(expYD),
        .sigXD(sigXD), .sigYD(sigYD), .kindD(kindD), .modeD(modeD)
    );

    fpMulSignificand significandStage (
        .clk(clk), .reset(reset), .validD(validD), .signD(signD),
        .expXD(expXD), .expYD(expYD), .sigXD(sigXD), .sigYD(sigYD),
        .kindD(kindD), .modeD(modeD),
        .validE(validE), .signE(signE), .expE(expE), .prodE(prodE),
        .kindE(kindE), .modeE(modeE)
    );

    fpMulNormRound normRoundStage (
        .clk(clk), .reset(reset), .validE(validE), .signE(signE),
        .expE(expE), .prodE(prodE), .kindE(kindE), .modeE(modeE),
        .outValid(outValid), .result(result),
        .overflow(overflow), .underflow(underflow)
    );

endmodule

// File: tests/fpMulChecker.sv
module fpMulChecker (
    input  logic                              clk,
    input  logic                              validE,
    input  logic [fpMulPkg::sigProdWidth-1:0] prodE,
    input  logic [fpMulPkg::normWidth-1:0]    normSig,
    input  logic [fpMulPkg::fracWidth:0]      roundSig,
    input  logic                              roundCarry,
    output int                                errorCount
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [fpMulPkg::sigProdWidth-1:0] shifted;
    logic [fpMulPkg::normWidth-1:0]    wantNorm;

    initial errorCount = 0;

    task automatic compareNorm(input logic [fpMulPkg::normWidth-1:0] got,
                               input logic [fpMulPkg::normWidth-1:0] want);
        if (got !== want) begin
            errorCount++;
            $display("MISMATCH normSig: got %h, expected %h", got, want);
        end
    endtask

    task automatic compareSig(input logic [fpMulPkg::fracWidth:0] got,
                              input logic [fpMulPkg::fracWidth:0] want);
        if (got !== want) begin
            errorCount++;
            $display("MISMATCH roundSig: got %h, expected %h", got, want);
        end
    endtask

    // last stage is stable between edges
    always @(negedge clk) begin
        if (validE === 1'b1) begin
            // leading one brought to bit 47 before the top bits are kept
            if (prodE[47]) begin
                shifted = prodE;
            end else begin
                shifted = prodE << 1;
            end
            wantNorm = {shifted[47:22], |shifted[21:0]};
            compareNorm(normSig, wantNorm);
            if (roundCarry === 1'b1) begin
                // a carry leaves exactly 1.0
                compareSig(roundSig, 24'h80_0000);
            end else if (roundSig[23] !== 1'b1) begin
                errorCount++;
                $display("rounded significand lost its leading one");
            end
        end
    end

endmodule

// File: include/fpMulModel.svh
`ifndef FP_MUL_MODEL_SVH
`define FP_MUL_MODEL_SVH

// round-up decision for a kept value with guard and remaining bits
function automatic logic modelRoundUp(input logic [2:0] mode, input logic sign,
                                      input logic lsb, input logic guard,
                                      input logic rest);
    case (mode)
        fpMulPkg::rmTowardZero: return 1'b0;
        fpMulPkg::rmDown:       return sign && (guard || rest);
        fpMulPkg::rmUp:         return !sign && (guard || rest);
        fpMulPkg::rmNearMax:    return guard;
        default:                return guard && (rest || lsb);
    endcase
endfunction

// packed as {overflow, underflow, result}
function automatic logic [33:0] modelProduct(input logic [31:0] x, input logic [31:0] y,
                                             input logic [2:0] mode);
    logic        sign;
    logic [7:0]  ex;
    logic [7:0]  ey;
    logic [47:0] prod;
    logic [23:0] keep;
    logic        guard;
    logic        rest;
    logic [24:0] sum;
    logic        toMax;
    int          expo;
    sign = x[31] ^ y[31];
    ex = x[30:23];
    ey = y[30:23];
    if ((ex == 8'hFF && x[22:0] != 0) || (ey == 8'hFF && y[22:0] != 0)) begin
        return {2'b00, fpMulPkg::canonNan};
    end
    if ((ex == 8'hFF && ey == 8'h00) || (ey == 8'hFF && ex == 8'h00)) begin
        return {2'b00, fpMulPkg::canonNan};
    end
    if (ex == 8'hFF || ey == 8'hFF) return {2'b00, sign, fpMulPkg::posInf[30:0]};
    if (ex == 8'h00 || ey == 8'h00) return {2'b00, sign, 31'b0};
    prod = {1'b1, x[22:0]} * {1'b1, y[22:0]};
    expo = int'(ex) + int'(ey) - fpMulPkg::expBias;
    if (prod[47]) begin
        keep = prod[47:24];
        guard = prod[23];
        rest = |prod[22:0];
        expo++;
    end else begin
        keep = prod[46:23];
        guard = prod[22];
        rest = |prod[21:0];
    end
    sum = {1'b0, keep} + 25'(modelRoundUp(mode, sign, keep[0], guard, rest));
    if (sum[24]) expo++;
    if (expo >= 255) begin
        toMax = (mode == fpMulPkg::rmTowardZero) || (mode == fpMulPkg::rmDown && !sign)
             || (mode == fpMulPkg::rmUp && sign);
        return {2'b10, sign, toMax ? fpMulPkg::maxFinite[30:0] : fpMulPkg::posInf[30:0]};
    end
    if (expo <= 0) return {2'b01, sign, 31'b0};
    return {2'b00, sign, 8'(expo), sum[24] ? sum[23:1] : sum[22:0]};
endfunction

`endif

// File: tests/fpMulTb.sv
module fpMulTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clkPeriod = 20;
    localparam int directedOps = 280;
    localparam int randomOps = 200;
    // one cycle per op, plus reset, drains and slack
    localparam int watchdogNs = (directedOps + randomOps + 200) * clkPeriod;

    logic        clk;
    logic        reset;
    logic        inValid;
    logic [31:0] opX;
    logic [31:0] opY;
    logic [2:0]  roundMode;
    logic        outValid;
    logic [31:0] result;
    logic        overflow;
    logic        underflow;

    logic [31:0] expResult[$];
    logic        expOverflow[$];
    logic        expUnderflow[$];
    int          strobeEdge[$];
    int          edgeCount = 0;
    int          mismatchCount = 0;
    int          otherErrors = 0;
    int          checkerErrors;
    int          wantEdge;

    `include "fpMulModel.svh"

    fpMulTop DUT (
        .clk(clk), .reset(reset), .inValid(inValid), .opX(opX), .opY(opY),
        .roundMode(roundMode), .outValid(outValid), .result(result),
        .overflow(overflow), .underflow(underflow)
    );

    fpMulChecker stageChecker (
        .clk(clk), .validE(DUT.validE), .prodE(DUT.prodE),
        .normSig(DUT.normRoundStage.normSig), .roundSig(DUT.normRoundStage.roundSig),
        .roundCarry(DUT.normRoundStage.roundCarry), .errorCount(checkerErrors)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) edgeCount <= edgeCount + 1;

    task automatic compareWord(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            mismatchCount++;
            $display("MISMATCH %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic want);
        if (got !== want) begin
            mismatchCount++;
            $display("MISMATCH %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic sendOp(input logic [31:0] x, input logic [31:0] y, input logic [2:0] mode);
        logic [33:0] want;
        @(negedge clk);
        inValid = 1'b1;
        opX = x;
        opY = y;
        roundMode = mode;
        want = modelProduct(x, y, mode);
        expResult.push_back(want[31:0]);
        expOverflow.push_back(want[33]);
        expUnderflow.push_back(want[32]);
        // cycle in which the strobe is presented
        strobeEdge.push_back(edgeCount);
    endtask

    // both signs of x in all five modes back to back
    task automatic sendEveryMode(input logic [31:0] x, input logic [31:0] y);
        int m;
        for (m = 0; m <= int'(fpMulPkg::rmNearMax); m++) begin
            sendOp(x, y, 3'(m));
            sendOp(x ^ 32'h8000_0000, y, 3'(m));
        end
    endtask

    task automatic finishBurst();
        int waited;
        @(negedge clk);
        inValid = 1'b0;
        waited = 0;
        while (expResult.size() != 0 && waited < fpMulPkg::latency + 4) begin
            @(negedge clk);
            waited++;
        end
        if (expResult.size() != 0) begin
            otherErrors++;
            $display("%0d results never arrived after the burst", expResult.size());
        end
    endtask

    function automatic logic [31:0] randomNormal();
        return {1'($urandom_range(1, 0)), 8'($urandom_range(190, 64)), 23'($urandom)};
    endfunction

    task automatic specialCases();
        sendEveryMode(32'h0000_0000, 32'h4040_0000);
        sendEveryMode(32'h0000_0001, 32'hC000_0000);
        sendEveryMode(32'h3F80_0000, 32'h807F_FFFF);
        sendEveryMode(32'h7F80_0000, 32'h4000_0000);
        sendEveryMode(32'h4000_0000, 32'hFF80_0000);
        sendEveryMode(32'h7F80_0000, 32'hFF80_0000);
        // inf times zero or a flushed subnormal
        sendEveryMode(32'h7F80_0000, 32'h0000_0000);
        sendEveryMode(32'h8000_0000, 32'hFF80_0000);
        sendEveryMode(32'h7F80_0000, 32'h0040_0000);
        sendEveryMode(32'h7FC0_0001, 32'h3F80_0000);
        sendEveryMode(32'h3F80_0000, 32'hFFFF_FFFF);
        sendEveryMode(32'h7F80_0001, 32'h7F80_0000);
        finishBurst();
    endtask

    task automatic roundingModes();
        // exact, odd tie, even tie, then inexact values
        sendEveryMode(32'h3FC0_0000, 32'h3FC0_0000);
        sendEveryMode(32'h3F80_0001, 32'h3FC0_0000);
        sendEveryMode(32'h3F80_0003, 32'h3FC0_0000);
        sendEveryMode(32'h3F8C_CCCD, 32'h3F8C_CCCD);
        sendEveryMode(32'h4049_0FDB, 32'h402D_F854);
        sendEveryMode(32'h3EAA_AAAB, 32'h4040_0000);
        finishBurst();
    endtask

    task automatic roundingCarry();
        sendEveryMode(32'h3FFF_FFFF, 32'h3FFF_FFFF);
        // just under 2.0 with a long tail
        sendEveryMode(32'h3FB5_04F3, 32'h3FB5_04F3);
        sendEveryMode(32'h3FFF_FFFF, 32'h3F80_0001);
        finishBurst();
    endtask

    task automatic rangeLimits();
        sendEveryMode(32'h7F00_0000, 32'h4000_0000);
        sendEveryMode(32'h7F7F_FFFF, 32'h7F7F_FFFF);
        sendEveryMode(32'h7F7F_FFFF, 32'h3F80_0001);
        sendEveryMode(32'h7F7F_FFFF, 32'h3F80_0000);
        // smallest normal and just below it
        sendEveryMode(32'h0080_0000, 32'h3F00_0000);
        sendEveryMode(32'h1F80_0000, 32'h1F80_0000);
        sendEveryMode(32'h0080_0000, 32'h3F80_0000);
        finishBurst();
    endtask

    task automatic randomBurst();
        int i;
        for (i = 0; i < randomOps; i++) begin
            sendOp(randomNormal(), randomNormal(), 3'($urandom_range(4, 0)));
        end
        finishBurst();
    endtask

    // results in order and each exactly latency cycles after its strobe
    always @(negedge clk) begin
        if (outValid === 1'b1) begin
            if (expResult.size() == 0) begin
                otherErrors++;
                $display("outValid high at edge %0d with no operation pending", edgeCount);
            end else begin
                wantEdge = strobeEdge.pop_front() + fpMulPkg::latency;
                if (edgeCount != wantEdge) begin
                    otherErrors++;
                    $display("result came at edge %0d instead of edge %0d", edgeCount, wantEdge);
                end
                compareWord("result", result, expResult.pop_front());
                compareFlag("overflow", overflow, expOverflow.pop_front());
                compareFlag("underflow", underflow, expUnderflow.pop_front());
            end
        end
    end

    initial begin
        void'($urandom(84));
        reset = 1'b1;
        inValid = 1'b0;
        opX = '0;
        opY = '0;
        roundMode = fpMulPkg::rmNearEven;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        if (outValid !== 1'b0) begin
            otherErrors++;
            $display("outValid is not low after reset");
        end
        specialCases();
        roundingModes();
        roundingCarry();
        rangeLimits();
        randomBurst();
        $display("mismatches %0d, checker errors %0d, other errors %0d",
                 mismatchCount, checkerErrors, otherErrors);
        if (mismatchCount + checkerErrors + otherErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired at %0t before the tests finished", $time);
        $display("mismatches %0d, checker errors %0d, other errors %0d",
                 mismatchCount, checkerErrors, otherErrors);
        $display("TB FAILED");
        $finish;
    end

endmodule
